//--- fetch_unit.f
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/icache_way.sv
hw/icache_ctrl.sv
hw/fetch_unit.sv
test/fetch_mem_model.sv
test/fetch_unit_tb.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/fetch_pc_gen.sv
      - hw/icache_way.sv
      - hw/icache_ctrl.sv
      - hw/fetch_unit.sv
  - target: test
    files:
      - test/fetch_mem_model.sv
      - test/fetch_unit_tb.sv

//--- test/fetch_unit_tb.sv
module fetch_unit_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	logic              clk = 1'b0;
	logic              rst;
	logic              redirect_valid;
	logic [addr_w-1:0] redirect_pc;
	logic              inst_valid;
	logic [inst_w-1:0] inst;
	logic [addr_w-1:0] inst_pc;
	logic              inst_pred_taken;
	logic              inst_ready;
	logic              mem_req_valid;
	logic [addr_w-1:0] mem_req_addr;
	logic              mem_req_ready;
	logic              mem_resp_valid;
	logic [inst_w-1:0] mem_resp_data;

	// own copy of the program window
	logic [31:0] image [1024];
	// reference pc and the last word taken by decode
	logic [31:0] exp_pc;
	logic [31:0] last_pc;
	logic        last_pred;

	always #4 clk = ~clk;

	fetch_unit u_dut (.*);

	fetch_mem_model u_mem (.*);

	// ************************************************************
	// reference model
	// ************************************************************

	function automatic logic [31:0] pattern_word(input logic [31:0] a);
		return {a[31:7] ^ a[24:0], 7'h13};
	endfunction

	function automatic logic [31:0] image_word(input logic [31:0] a);
		if (a[31:12] == 20'h80000) begin
			return image[a[11:2]];
		end
		return pattern_word(a);
	endfunction

	function automatic logic [31:0] enc_jal(input int off);
		logic [20:0] i;
		i = 21'(off);
		return {i[20], i[10:1], i[11], i[19:12], 5'd0, 7'h6f};
	endfunction

	// bne x1, x2
	function automatic logic [31:0] enc_bne(input int off);
		logic [12:0] i;
		i = 13'(off);
		return {i[12], i[10:5], 5'd2, 5'd1, 3'b001, i[4:1], i[11], 7'h63};
	endfunction

	// jal always taken and conditional branches only when backward
	function automatic logic taken(input logic [31:0] w);
		if (w[6:0] == 7'h6f) begin
			return 1'b1;
		end
		return (w[6:0] == 7'h63) && (w[14:12] != 3'b010) && (w[14:12] != 3'b011) && w[31];
	endfunction

	function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
		logic [31:0] jimm;
		logic [31:0] bimm;
		jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		if (!taken(w)) begin
			return pc + 32'd4;
		end
		return pc + ((w[6:0] == 7'h6f) ? jimm : bimm);
	endfunction

	// ************************************************************
	// helpers
	// ************************************************************

	task automatic check_eq(input string test, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", test, exp, act);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic put_word(input logic [31:0] a, input logic [31:0] w);
		image[a[11:2]] = w;
		u_mem.image[a[11:2]] = w;
	endtask

	// compare the word at the register output with the reference
	task automatic check_inst(input string test);
		check_eq(test, exp_pc, inst_pc);
		check_eq(test, image_word(exp_pc), inst);
		check_eq(test, taken(image_word(exp_pc)), inst_pred_taken);
		last_pc = inst_pc;
		last_pred = inst_pred_taken;
		exp_pc = next_pc(exp_pc, image_word(exp_pc));
	endtask

	// decode takes one word starting from a falling edge
	task automatic take_inst(input string test);
		int n;
		n = 0;
		inst_ready = 1'b1;
		while (!inst_valid) begin
			@(negedge clk);
			n++;
			if (n > 300) begin
				report_failure({test, ": no instruction reached decode in time"});
			end
		end
		check_inst(test);
		@(negedge clk);
		inst_ready = 1'b0;
	endtask

	// random ready with held words checked for stability
	task automatic take_random(input string test, input int count);
		int n;
		int got;
		logic held;
		logic [31:0] hold_pc;
		logic [31:0] hold_inst;
		n = 0;
		got = 0;
		held = 1'b0;
		while (got < count) begin
			inst_ready = ($urandom_range(0, 3) != 0);
			if (held) begin
				check_eq({test, " held valid"}, 1, inst_valid);
				check_eq({test, " held pc"}, hold_pc, inst_pc);
				check_eq({test, " held inst"}, hold_inst, inst);
			end
			if (inst_valid && inst_ready) begin
				check_inst(test);
				got++;
				held = 1'b0;
				n = 0;
			end else begin
				held = inst_valid;
				hold_pc = inst_pc;
				hold_inst = inst;
			end
			@(negedge clk);
			n++;
			if (n > 300) begin
				report_failure({test, ": decode stalled waiting for the next word"});
			end
		end
		inst_ready = 1'b0;
	endtask

	// one cycle redirect from execute
	task automatic go_to(input logic [31:0] a);
		inst_ready = 1'b0;
		redirect_valid = 1'b1;
		redirect_pc = a;
		@(negedge clk);
		redirect_valid = 1'b0;
		exp_pc = a;
	endtask

	function automatic int line_reqs(input logic [31:0] a);
		return u_mem.line_count[a[11:4]];
	endfunction

	// ************************************************************
	// directed tests
	// ************************************************************

	task automatic straight_line();
		exp_pc = reset_pc;
		take_inst("straight");
		check_eq("straight first line", 1, line_reqs(reset_pc));
		for (int i = 0; i < 3; i++) begin
			take_inst("straight");
		end
		check_eq("straight same line", 1, line_reqs(reset_pc));
	endtask

	task automatic jal_taken();
		go_to(32'h8000_0100);
		take_inst("jal");
		check_eq("jal predicted", 1, last_pred);
		take_inst("jal");
		check_eq("jal target", 32'h8000_0120, last_pc);
	endtask

	task automatic branch_direction();
		go_to(32'h8000_0200);
		take_inst("branch fwd");
		check_eq("branch fwd pred", 0, last_pred);
		take_inst("branch fwd");
		check_eq("branch fwd next", 32'h8000_0204, last_pc);
		take_inst("branch back");
		take_inst("branch back");
		check_eq("branch back pred", 1, last_pred);
		take_inst("branch back");
		check_eq("branch back target", 32'h8000_0204, last_pc);
	endtask

	task automatic redirect_flush();
		go_to(32'h8000_0204);
		take_inst("redirect loop");
		take_inst("redirect loop");
		// loop keeps the register full when the redirect lands
		@(negedge clk);
		// mid-line target in a line not yet cached
		go_to(32'h8000_0088);
		take_inst("redirect");
		check_eq("redirect target", 32'h8000_0088, last_pc);
		take_inst("redirect");
	endtask

	task automatic random_backpressure();
		go_to(32'h8000_0600);
		take_random("backpressure", 24);
	endtask

	// three lines in set 15
	task automatic lru_replacement();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		a = 32'h8000_0cf0;
		b = 32'h8000_0df0;
		c = 32'h8000_0ef0;
		go_to(a);
		take_inst("lru a");
		go_to(b);
		take_inst("lru b");
		go_to(a);
		take_inst("lru a again");
		go_to(c);
		take_inst("lru c");
		go_to(a);
		take_inst("lru a last");
		check_eq("lru a requests", 1, line_reqs(a));
		check_eq("lru b requests", 1, line_reqs(b));
		check_eq("lru c requests", 1, line_reqs(c));
	endtask

	initial begin
		void'($urandom(32'he7af_0b3d));
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		inst_ready = 1'b0;
		@(negedge clk);
		for (int i = 0; i < 1024; i++) begin
			image[i] = pattern_word(32'h8000_0000 | (i << 2));
		end
		put_word(32'h8000_0100, enc_jal(32));
		put_word(32'h8000_0200, enc_bne(16));
		// loops back to 0x204
		put_word(32'h8000_020c, enc_bne(-8));
		repeat (9) @(negedge clk);
		rst = 1'b0;
		straight_line();
		jal_taken();
		branch_direction();
		redirect_flush();
		random_backpressure();
		lru_replacement();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- test/fetch_mem_model.sv
module fetch_mem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic        mem_req_valid,
	input  logic [31:0] mem_req_addr,
	output logic        mem_req_ready,
	output logic        mem_resp_valid,
	output logic [31:0] mem_resp_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// program window, 4 KiB at the boot address
	logic [31:0] image [1024];
	// line requests seen, one counter per line of the window
	int          line_count [256];
	logic [31:0] line_addr;

	// background words, all addi, payload mixes every address bit
	function automatic logic [31:0] pattern_word(input logic [31:0] a);
		return {a[31:7] ^ a[24:0], 7'h13};
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (a[31:12] == 20'h80000) begin
			return image[a[11:2]];
		end
		return pattern_word(a);
	endfunction

	// ************************************************************
	// image and counters
	// ************************************************************

	initial begin
		for (int i = 0; i < 1024; i++) begin
			image[i] = pattern_word(32'h8000_0000 | (i << 2));
		end
		for (int i = 0; i < 256; i++) begin
			line_count[i] = 0;
		end
	end

	// ************************************************************
	// request and beat sequencing
	// ************************************************************

	initial begin : serve
		int d;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		forever begin
			@(negedge clk);
			if (!rst && mem_req_valid) begin
				// random accept delay, request stays high meanwhile
				d = $urandom_range(0, 3);
				repeat (d) @(negedge clk);
				line_addr = mem_req_addr;
				mem_req_ready = 1'b1;
				if (line_addr[31:12] == 20'h80000) begin
					line_count[line_addr[11:4]]++;
				end
				@(negedge clk);
				mem_req_ready = 1'b0;
				// gap before the first beat
				d = $urandom_range(0, 5);
				repeat (d) @(negedge clk);
				// four beats back to back, lowest word first
				for (int b = 0; b < 4; b++) begin
					mem_resp_valid = 1'b1;
					mem_resp_data = word_at(line_addr + 32'(4 * b));
					@(negedge clk);
				end
				mem_resp_valid = 1'b0;
			end
		end
	end

endmodule

//--- hw/fetch_unit.sv
module fetch_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         redirect_valid,
	input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
	output logic                         inst_valid,
	output logic [fetch_pkg::inst_w-1:0] inst,
	output logic [fetch_pkg::addr_w-1:0] inst_pc,
	output logic                         inst_pred_taken,
	input  logic                         inst_ready,
	output logic                         mem_req_valid,
	output logic [fetch_pkg::addr_w-1:0] mem_req_addr,
	input  logic                         mem_req_ready,
	input  logic                         mem_resp_valid,
	input  logic [fetch_pkg::inst_w-1:0] mem_resp_data
);
	import fetch_pkg::*;

	// pc generator to cache
	logic                            req_valid;
	logic [addr_w-1:0]               req_pc;
	logic                            req_ready;
	logic                            squash;
	logic                            resp_valid;
	logic [inst_w-1:0]               resp_inst;
	logic [addr_w-1:0]               resp_pc;
	logic                            resp_pred_taken;
	// lookup side of the ways
	logic [index_w-1:0]              lookup_index;
	logic [tag_w-1:0]                lookup_tag;
	logic [word_w-1:0]               lookup_word;
	logic [num_ways-1:0]             way_hit;
	logic [num_ways-1:0][inst_w-1:0] way_word;
	// refill side
	logic [num_ways-1:0]             fill_way;
	logic [index_w-1:0]              fill_index;
	logic [word_w-1:0]               fill_word;
	logic [tag_w-1:0]                fill_tag;
	logic [inst_w-1:0]               fill_data;
	logic                            fill_last;

	fetch_pc_gen u_pc_gen (
		.clk             (clk),
		.rst             (rst),
		.redirect_valid  (redirect_valid),
		.redirect_pc     (redirect_pc),
		.req_valid       (req_valid),
		.req_pc          (req_pc),
		.req_ready       (req_ready),
		.resp_valid      (resp_valid),
		.resp_inst       (resp_inst),
		.resp_pc         (resp_pc),
		.resp_pred_taken (resp_pred_taken),
		.squash          (squash)
	);

	// new index from the pc when a request can go in,
	// otherwise re-read the set of the pending lookup
	assign lookup_index = req_ready ? req_pc[offset_w +: index_w] : fill_index;

	for (genvar g = 0; g < num_ways; g++) begin : g_way
		icache_way u_way (
			.clk          (clk),
			.rst          (rst),
			.lookup_index (lookup_index),
			.lookup_tag   (lookup_tag),
			.lookup_word  (lookup_word),
			.hit          (way_hit[g]),
			.rd_word      (way_word[g]),
			.fill_en      (fill_way[g]),
			.fill_index   (fill_index),
			.fill_word    (fill_word),
			.fill_tag     (fill_tag),
			.fill_data    (fill_data),
			// last beat only reaches the way being filled
			.fill_last    (fill_last & fill_way[g])
		);
	end

	icache_ctrl u_ctrl (
		.clk             (clk),
		.rst             (rst),
		.req_valid       (req_valid),
		.req_pc          (req_pc),
		.req_ready       (req_ready),
		.squash          (squash),
		.redirect_valid  (redirect_valid),
		.way_hit         (way_hit),
		.way_word        (way_word),
		.lookup_tag      (lookup_tag),
		.lookup_word     (lookup_word),
		.fill_way        (fill_way),
		.fill_index      (fill_index),
		.fill_word       (fill_word),
		.fill_tag        (fill_tag),
		.fill_data       (fill_data),
		.fill_last       (fill_last),
		.resp_valid      (resp_valid),
		.resp_inst       (resp_inst),
		.resp_pc         (resp_pc),
		.resp_pred_taken (resp_pred_taken),
		.inst_valid      (inst_valid),
		.inst            (inst),
		.inst_pc         (inst_pc),
		.inst_pred_taken (inst_pred_taken),
		.inst_ready      (inst_ready),
		.mem_req_valid   (mem_req_valid),
		.mem_req_addr    (mem_req_addr),
		.mem_req_ready   (mem_req_ready),
		.mem_resp_valid  (mem_resp_valid),
		.mem_resp_data   (mem_resp_data)
	);

endmodule

//--- hw/icache_ctrl.sv
module icache_ctrl (
	input  logic                                               clk,
	input  logic                                               rst,
	input  logic                                               req_valid,
	input  logic [fetch_pkg::addr_w-1:0]                       req_pc,
	output logic                                               req_ready,
	input  logic                                               squash,
	input  logic                                               redirect_valid,
	input  logic [fetch_pkg::num_ways-1:0]                     way_hit,
	input  logic [fetch_pkg::num_ways-1:0][fetch_pkg::inst_w-1:0] way_word,
	output logic [fetch_pkg::tag_w-1:0]                        lookup_tag,
	output logic [fetch_pkg::word_w-1:0]                       lookup_word,
	output logic [fetch_pkg::num_ways-1:0]                     fill_way,
	output logic [fetch_pkg::index_w-1:0]                      fill_index,
	output logic [fetch_pkg::word_w-1:0]                       fill_word,
	output logic [fetch_pkg::tag_w-1:0]                        fill_tag,
	output logic [fetch_pkg::inst_w-1:0]                       fill_data,
	output logic                                               fill_last,
	output logic                                               resp_valid,
	output logic [fetch_pkg::inst_w-1:0]                       resp_inst,
	output logic [fetch_pkg::addr_w-1:0]                       resp_pc,
	input  logic                                               resp_pred_taken,
	output logic                                               inst_valid,
	output logic [fetch_pkg::inst_w-1:0]                       inst,
	output logic [fetch_pkg::addr_w-1:0]                       inst_pc,
	output logic                                               inst_pred_taken,
	input  logic                                               inst_ready,
	output logic                                               mem_req_valid,
	output logic [fetch_pkg::addr_w-1:0]                       mem_req_addr,
	input  logic                                               mem_req_ready,
	input  logic                                               mem_resp_valid,
	input  logic [fetch_pkg::inst_w-1:0]                       mem_resp_data
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {s_idle, s_req, s_fill, s_replay} state_t;

	state_t              state;
	logic [word_w-1:0]   beat_cnt;
	logic                victim_q;
	logic [num_sets-1:0] lru_q;
	logic                lk_valid;
	logic [addr_w-1:0]   lk_pc;
	logic [index_w-1:0]  lk_index;
	logic                lookup_state;
	logic                rsp_free;
	logic                hit_any;
	logic                hit_way;
	logic [inst_w-1:0]   hit_word;
	logic                beat_last;

	// ************************************************************
	// pending lookup
	// ************************************************************

	assign lk_index = lk_pc[offset_w +: index_w];
	assign lookup_tag = lk_pc[addr_w-1 -: tag_w];
	assign lookup_word = lk_pc[offset_w-1:2];

	// ways answer only in idle and replay
	assign lookup_state = (state == s_idle) || (state == s_replay);
	// response register empty or draining this cycle
	assign rsp_free = !inst_valid || inst_ready;

	// merge the way outputs
	always_comb begin
		hit_any = 1'b0;
		hit_way = 1'b0;
		hit_word = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (way_hit[w]) begin
				hit_any = 1'b1;
				hit_way = w[0];
				hit_word = way_word[w];
			end
		end
	end

	// new lookup only once the current one leaves, hit and room
	assign req_ready = (state == s_idle) && (!lk_valid || (hit_any && rsp_free));

	// word enters the response register, pre-decoded by the pc generator
	assign resp_valid = lookup_state && lk_valid && hit_any && rsp_free && !redirect_valid;
	assign resp_inst = hit_word;
	assign resp_pc = lk_pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			lk_valid <= 1'b0;
		end else if (req_valid && req_ready) begin
			// wrong path after a taken prediction or a redirect
			lk_valid <= !squash && !redirect_valid;
		end else if (redirect_valid || resp_valid) begin
			lk_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			lk_pc <= req_pc;
		end
	end

	// ************************************************************
	// response register towards decode
	// ************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (redirect_valid) begin
			inst_valid <= 1'b0;
		end else if (resp_valid) begin
			inst_valid <= 1'b1;
		end else if (inst_ready) begin
			inst_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_valid) begin
			inst <= hit_word;
			inst_pc <= lk_pc;
			inst_pred_taken <= resp_pred_taken;
		end
	end

	// ************************************************************
	// refill FSM
	// ************************************************************

	assign beat_last = (beat_cnt == word_w'(line_words - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			beat_cnt <= '0;
		end else begin
			case (state)
				s_idle: begin
					// miss seen in the lookup cycle
					if (lk_valid && !hit_any && !redirect_valid) begin
						state <= s_req;
					end
				end
				s_req: begin
					if (mem_req_ready) begin
						state <= s_fill;
						beat_cnt <= '0;
					end
				end
				s_fill: begin
					if (mem_resp_valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						// discarded lookup, line still filled but no word returned
						if (beat_last) begin
							state <= (lk_valid && !redirect_valid) ? s_replay : s_idle;
						end
					end
				end
				default: begin
					// stay only while the word waits on decode
					if (redirect_valid || !(lk_valid && hit_any && !rsp_free)) begin
						state <= s_idle;
					end
				end
			endcase
		end
	end

	// victim is the way not used last in this set
	always_ff @(posedge clk) begin
		if (state == s_idle && lk_valid && !hit_any) begin
			victim_q <= ~lru_q[lk_index];
		end
	end

	// lru bit holds the most recently used way
	always_ff @(posedge clk) begin
		if (rst) begin
			lru_q <= '0;
		end else if (fill_last) begin
			lru_q[lk_index] <= victim_q;
		end else if (lookup_state && lk_valid && hit_any) begin
			lru_q[lk_index] <= hit_way;
		end
	end

	// line aligned request for the pending lookup
	assign mem_req_valid = (state == s_req);
	assign mem_req_addr = {lk_pc[addr_w-1:offset_w], {offset_w{1'b0}}};

	// beats go straight into the victim way
	assign fill_way = (state == s_fill && mem_resp_valid) ? (num_ways'(1) << victim_q) : '0;
	assign fill_index = lk_index;
	assign fill_word = beat_cnt;
	assign fill_tag = lk_pc[addr_w-1 -: tag_w];
	assign fill_data = mem_resp_data;
	assign fill_last = (state == s_fill) && mem_resp_valid && beat_last;

	// a line lives in at most one way
	hit_onehot: assert property (@(posedge clk) disable iff (rst)
		(lookup_state && lk_valid) |-> $onehot0(way_hit));

	// beats only inside a refill, counter bounds them to line_words
	beats_in_fill: assert property (@(posedge clk) disable iff (rst)
		mem_resp_valid |-> (state == s_fill));

endmodule

//--- hw/icache_way.sv
module icache_way (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [fetch_pkg::index_w-1:0] lookup_index,
	input  logic [fetch_pkg::tag_w-1:0]   lookup_tag,
	input  logic [fetch_pkg::word_w-1:0]  lookup_word,
	output logic                          hit,
	output logic [fetch_pkg::inst_w-1:0]  rd_word,
	input  logic                          fill_en,
	input  logic [fetch_pkg::index_w-1:0] fill_index,
	input  logic [fetch_pkg::word_w-1:0]  fill_word,
	input  logic [fetch_pkg::tag_w-1:0]   fill_tag,
	input  logic [fetch_pkg::inst_w-1:0]  fill_data,
	input  logic                          fill_last
);
	import fetch_pkg::*;

	// per set state of this way
	logic [num_sets-1:0] valid_q;
	logic [tag_w-1:0]    tag_q [num_sets];
	logic [inst_w-1:0]   data_q [num_sets][line_words];
	// set being looked up this cycle
	logic [index_w-1:0]  index_q;

	// index captured every cycle
	always_ff @(posedge clk) begin
		index_q <= lookup_index;
	end

	// line invalid while beats arrive, valid on the last one
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (fill_en) begin
			valid_q[fill_index] <= fill_last;
		end
	end

	// tag rewritten on each beat, same value
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[fill_index] <= fill_tag;
			data_q[fill_index][fill_word] <= fill_data;
		end
	end

	// compare against the controller's registered tag
	assign hit = valid_q[index_q] && (tag_q[index_q] == lookup_tag);
	assign rd_word = data_q[index_q][lookup_word];

	// only the victim way may complete a line
	fill_last_en: assert property (@(posedge clk) disable iff (rst)
		fill_last |-> fill_en);

endmodule

//--- hw/fetch_pc_gen.sv
module fetch_pc_gen (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          redirect_valid,
	input  logic [fetch_pkg::addr_w-1:0]  redirect_pc,
	output logic                          req_valid,
	output logic [fetch_pkg::addr_w-1:0]  req_pc,
	input  logic                          req_ready,
	input  logic                          resp_valid,
	input  logic [fetch_pkg::inst_w-1:0]  resp_inst,
	input  logic [fetch_pkg::addr_w-1:0]  resp_pc,
	output logic                          resp_pred_taken,
	output logic                          squash
);
	import fetch_pkg::*;

	logic [addr_w-1:0] pc_q;
	logic              pc_valid_q;
	logic [addr_w-1:0] pc_next;
	logic [6:0]        opcode;
	logic              is_jal;
	logic              is_branch;
	logic              branch_back;
	logic [addr_w-1:0] imm_j;
	logic [addr_w-1:0] imm_b;
	logic [addr_w-1:0] pred_target;

	// ************************************************************
	// pre-decode of the word entering the response register
	// ************************************************************

	assign opcode = resp_inst[6:0];
	assign is_jal = (opcode == op_jal);
	// funct3 010 and 011 are not branches
	assign is_branch = (opcode == op_branch) && (resp_inst[14:13] != 2'b01);
	// sign bit set means negative offset
	assign branch_back = is_branch && resp_inst[31];

	// J immediate, 21 bits sign extended
	assign imm_j = {{(addr_w-20){resp_inst[31]}}, resp_inst[19:12], resp_inst[20],
		resp_inst[30:21], 1'b0};
	// B immediate, 13 bits sign extended
	assign imm_b = {{(addr_w-12){resp_inst[31]}}, resp_inst[7], resp_inst[30:25],
		resp_inst[11:8], 1'b0};

	// target relative to the predicted word, not the current pc
	assign pred_target = resp_pc + (is_jal ? imm_j : imm_b);

	// static rule: jal and backward branches taken
	assign resp_pred_taken = resp_valid && (is_jal || branch_back);

	// the sequential request accepted alongside a taken response is wrong path
	assign squash = resp_pred_taken;

	// ************************************************************
	// pc register
	// ************************************************************

	// priority: redirect, prediction, sequential
	always_comb begin
		if (redirect_valid) begin
			pc_next = redirect_pc;
		end else if (resp_pred_taken) begin
			pc_next = pred_target;
		end else if (req_valid && req_ready) begin
			pc_next = pc_q + addr_w'(4);
		end else begin
			// held by back-pressure or refill
			pc_next = pc_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= reset_pc;
			pc_valid_q <= 1'b0;
		end else begin
			pc_q <= pc_next;
			// requests start one cycle after reset
			pc_valid_q <= 1'b1;
		end
	end

	assign req_valid = pc_valid_q;
	assign req_pc = pc_q;

	// ************************************************************
	// checks
	// ************************************************************

	// redirect targets and predicted targets must stay word aligned
	req_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> (req_pc[1:0] == 2'b00));

	// a rise of req_valid only after a cycle out of reset
	req_valid_rst_low: assert property (@(posedge clk)
		$rose(req_valid) |-> !$past(rst));

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

	// ************************************************************
	// widths
	// ************************************************************

	// byte address, full 32 bit space
	localparam int addr_w = 32;
	// base isa words only, no compressed
	localparam int inst_w = 32;

	// boot address of the program image
	localparam logic [addr_w-1:0] reset_pc = 32'h8000_0000;

	// ************************************************************
	// cache geometry
	// ************************************************************

	// one memory beat per word
	localparam int line_words = 4;
	localparam int num_sets = 16;
	// two ways, one lru bit per set covers it
	localparam int num_ways = 2;

	// word select inside a line
	localparam int word_w = $clog2(line_words);
	// word select plus the two byte bits
	localparam int offset_w = word_w + 2;
	localparam int index_w = $clog2(num_sets);
	// everything above index and offset
	localparam int tag_w = addr_w - index_w - offset_w;

	// ************************************************************
	// pre-decode
	// ************************************************************

	// jal, always predicted taken
	localparam logic [6:0] op_jal = 7'b1101111;
	// beq/bne/blt/bge/bltu/bgeu share this opcode
	localparam logic [6:0] op_branch = 7'b1100011;

endpackage
